// File: logic/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Width of one bus word
`define DATA_WIDTH 32

// General registers r0 to r7
`define REG_COUNT 8

// Opcode field width
`define OP_CODE_WIDTH 5

`endif

// File: logic/alu_pkg.sv
`include "cpu_config.svh"

package alu_pkg;

	// Encodings follow the instruction set of the teaching processor
	typedef enum logic [`OP_CODE_WIDTH-1:0] {
		op_ld   = 5'd0,
		op_ldi  = 5'd1,
		op_st   = 5'd2,
		op_add  = 5'd3,
		op_sub  = 5'd4,
		op_shr  = 5'd5,
		op_shra = 5'd6,
		op_shl  = 5'd7,
		op_ror  = 5'd8,
		op_rol  = 5'd9,
		op_and  = 5'd10,
		op_or   = 5'd11,
		op_addi = 5'd12,
		op_andi = 5'd13,
		op_ori  = 5'd14,
		op_mul  = 5'd15,
		op_div  = 5'd16,
		op_neg  = 5'd17,
		op_not  = 5'd18
	} op_code_t;

	// Full ALU result, high half first
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] hi;
		logic [`DATA_WIDTH-1:0] lo;
	} dword_t;

endpackage

// File: logic/bus_pkg.sv
`include "cpu_config.svh"

package bus_pkg;

	typedef logic [`DATA_WIDTH-1:0] word_t;

	// Listed highest priority first
	// When several out strobes are set the earliest entry drives the bus
	typedef enum logic [3:0] {
		src_mdr,
		src_pc,
		src_zlo,
		src_zhi,
		src_hi,
		src_lo,
		src_r0,
		src_r1,
		src_r2,
		src_r3,
		src_r4,
		src_r5,
		src_r6,
		src_r7,
		src_none
	} bus_src_t;

endpackage

// File: logic/data_register.sv
module data_register
	import bus_pkg::*;
#(
	parameter type payload_t = word_t
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     clr,
	input  logic     load,
	input  payload_t d,
	output payload_t q
);

	// Synchronous clear wins over load
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (clr) begin
			q <= '0;
		end else if (load) begin
			q <= d;
		end
	end

endmodule

// File: logic/mdr_unit.sv
module mdr_unit
	import bus_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  clr,
	input  logic  mdr_enable,
	input  logic  read,
	input  word_t m_data_in,
	input  word_t bus_data,
	output word_t mdr_data
);

	word_t mdr_next;

	// Memory side during a read, otherwise a write-back value from the bus
	assign mdr_next = read ? m_data_in : bus_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mdr_data <= '0;
		end else if (clr) begin
			mdr_data <= '0;
		end else if (mdr_enable) begin
			mdr_data <= mdr_next;
		end
	end

endmodule

// File: logic/bus_mux.sv
`include "cpu_config.svh"

module bus_mux
	import bus_pkg::*;
(
	input  logic                  mdr_out,
	input  logic                  pc_out,
	input  logic                  zlo_out,
	input  logic                  zhi_out,
	input  logic                  hi_out,
	input  logic                  lo_out,
	input  logic [`REG_COUNT-1:0] r_out,
	input  word_t                 mdr_data,
	input  word_t                 pc_data,
	input  word_t                 zlo_data,
	input  word_t                 zhi_data,
	input  word_t                 hi_data,
	input  word_t                 lo_data,
	input  word_t                 reg_data [`REG_COUNT],
	output word_t                 bus_data
);

	localparam int IDX_W = $clog2(`REG_COUNT);

	bus_src_t         sel;
	logic [IDX_W-1:0] reg_idx;

	// Priority encoder over the out strobes
	always_comb begin
		sel = src_none;
		if (mdr_out) begin
			sel = src_mdr;
		end else if (pc_out) begin
			sel = src_pc;
		end else if (zlo_out) begin
			sel = src_zlo;
		end else if (zhi_out) begin
			sel = src_zhi;
		end else if (hi_out) begin
			sel = src_hi;
		end else if (lo_out) begin
			sel = src_lo;
		end else begin
			// Walk down so the lowest numbered register wins
			for (int i = `REG_COUNT - 1; i >= 0; i--) begin
				if (r_out[i]) begin
					sel = bus_src_t'(int'(src_r0) + i);
				end
			end
		end
	end

	// Only meaningful for the r0..r7 sources
	assign reg_idx = IDX_W'(int'(sel) - int'(src_r0));

	always_comb begin
		case (sel)
			src_mdr:  bus_data = mdr_data;
			src_pc:   bus_data = pc_data;
			src_zlo:  bus_data = zlo_data;
			src_zhi:  bus_data = zhi_data;
			src_hi:   bus_data = hi_data;
			src_lo:   bus_data = lo_data;
			src_none: bus_data = '0;
			default:  bus_data = reg_data[reg_idx];
		endcase
	end

endmodule

// File: logic/alu.sv
`include "cpu_config.svh"

module alu
	import alu_pkg::*;
	import bus_pkg::*;
(
	input  op_code_t op_code,
	input  logic     pc_increment,
	input  word_t    a,
	input  word_t    b,
	output dword_t   result
);

	logic [4:0]                       shamt;
	logic signed [`DATA_WIDTH-1:0]    a_s;
	logic signed [`DATA_WIDTH-1:0]    b_s;
	logic signed [2*`DATA_WIDTH-1:0]  product;
	logic signed [`DATA_WIDTH-1:0]    quotient;
	logic signed [`DATA_WIDTH-1:0]    remainder;
	logic [2*`DATA_WIDTH-1:0]         a_pair;
	logic [2*`DATA_WIDTH-1:0]         rot_right;
	logic [2*`DATA_WIDTH-1:0]         rot_left;

	// Shift and rotate amounts use only the low five bits of b
	assign shamt = b[4:0];

	assign a_s = a;
	assign b_s = b;

	// Signed operands give a sign-extended 64-bit product
	assign product = (2*`DATA_WIDTH)'(a_s) * (2*`DATA_WIDTH)'(b_s);

	// Truncating divide with the remainder taking the dividend's sign
	always_comb begin
		if (b == '0) begin
			quotient  = '1;
			remainder = a_s;
		end else begin
			quotient  = a_s / b_s;
			remainder = a_s % b_s;
		end
	end

	// Rotates from a doubled copy of a
	assign a_pair    = {a, a};
	assign rot_right = a_pair >> shamt;
	assign rot_left  = a_pair << shamt;

	always_comb begin
		result = '0;
		if (pc_increment) begin
			// PC step ignores op_code
			result.lo = b + word_t'(1);
		end else begin
			case (op_code)
				op_ld, op_ldi, op_st, op_add, op_addi: begin
					result.lo = a + b;
				end
				op_sub: begin
					result.lo = a - b;
				end
				op_and, op_andi: begin
					result.lo = a & b;
				end
				op_or, op_ori: begin
					result.lo = a | b;
				end
				op_shr: begin
					result.lo = a >> shamt;
				end
				op_shra: begin
					result.lo = a_s >>> shamt;
				end
				op_shl: begin
					result.lo = a << shamt;
				end
				op_ror: begin
					result.lo = rot_right[`DATA_WIDTH-1:0];
				end
				op_rol: begin
					result.lo = rot_left[2*`DATA_WIDTH-1:`DATA_WIDTH];
				end
				op_mul: begin
					result = product;
				end
				op_div: begin
					result.lo = quotient;
					result.hi = remainder;
				end
				op_neg: begin
					result.lo = -b;
				end
				op_not: begin
					result.lo = ~b;
				end
				default: begin
					// Unused opcodes 19 to 31
					result = '0;
				end
			endcase
		end
	end

endmodule

// File: logic/datapath.sv
`include "cpu_config.svh"

module datapath
	import alu_pkg::*;
	import bus_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  clr,
	input  logic                  pc_out,
	input  logic                  zlo_out,
	input  logic                  zhi_out,
	input  logic                  mdr_out,
	input  logic                  hi_out,
	input  logic                  lo_out,
	input  logic [`REG_COUNT-1:0] r_out,
	input  logic [`REG_COUNT-1:0] r_enable,
	input  logic                  mar_enable,
	input  logic                  z_enable,
	input  logic                  lo_enable,
	input  logic                  hi_enable,
	input  logic                  pc_enable,
	input  logic                  mdr_enable,
	input  logic                  read,
	input  logic                  ir_enable,
	input  logic                  y_enable,
	input  logic                  pc_increment,
	input  op_code_t              op_code,
	input  word_t                 m_data_in,
	output word_t                 bus_data,
	output word_t                 zlo_data,
	output word_t                 zhi_data,
	output word_t                 ir_data,
	output word_t                 mar_data
);

	word_t  pc_data;
	word_t  y_data;
	word_t  hi_data;
	word_t  lo_data;
	word_t  mdr_data;
	word_t  reg_data [`REG_COUNT];
	dword_t alu_result;
	dword_t z_data;

	// Special purpose word registers, all loaded from the bus
	data_register #(.payload_t(word_t)) pc_reg (
		.clk(clk), .arst_n(arst_n), .clr(clr),
		.load(pc_enable), .d(bus_data), .q(pc_data)
	);

	data_register #(.payload_t(word_t)) ir_reg (
		.clk(clk), .arst_n(arst_n), .clr(clr),
		.load(ir_enable), .d(bus_data), .q(ir_data)
	);

	data_register #(.payload_t(word_t)) mar_reg (
		.clk(clk), .arst_n(arst_n), .clr(clr),
		.load(mar_enable), .d(bus_data), .q(mar_data)
	);

	// Holds ALU operand a
	data_register #(.payload_t(word_t)) y_reg (
		.clk(clk), .arst_n(arst_n), .clr(clr),
		.load(y_enable), .d(bus_data), .q(y_data)
	);

	data_register #(.payload_t(word_t)) hi_reg (
		.clk(clk), .arst_n(arst_n), .clr(clr),
		.load(hi_enable), .d(bus_data), .q(hi_data)
	);

	data_register #(.payload_t(word_t)) lo_reg (
		.clk(clk), .arst_n(arst_n), .clr(clr),
		.load(lo_enable), .d(bus_data), .q(lo_data)
	);

	// General register file r0 to r7
	for (genvar i = 0; i < `REG_COUNT; i++) begin : g_gpr
		data_register #(.payload_t(word_t)) gpr (
			.clk(clk), .arst_n(arst_n), .clr(clr),
			.load(r_enable[i]), .d(bus_data), .q(reg_data[i])
		);
	end

	// Z takes the full 64-bit result
	data_register #(.payload_t(dword_t)) z_reg (
		.clk(clk), .arst_n(arst_n), .clr(clr),
		.load(z_enable), .d(alu_result), .q(z_data)
	);

	assign zlo_data = z_data.lo;
	assign zhi_data = z_data.hi;

	mdr_unit mdr (
		.clk(clk),
		.arst_n(arst_n),
		.clr(clr),
		.mdr_enable(mdr_enable),
		.read(read),
		.m_data_in(m_data_in),
		.bus_data(bus_data),
		.mdr_data(mdr_data)
	);

	bus_mux bus (
		.mdr_out(mdr_out),
		.pc_out(pc_out),
		.zlo_out(zlo_out),
		.zhi_out(zhi_out),
		.hi_out(hi_out),
		.lo_out(lo_out),
		.r_out(r_out),
		.mdr_data(mdr_data),
		.pc_data(pc_data),
		.zlo_data(zlo_data),
		.zhi_data(zhi_data),
		.hi_data(hi_data),
		.lo_data(lo_data),
		.reg_data(reg_data),
		.bus_data(bus_data)
	);

	// Operand a from Y, operand b straight off the bus
	alu alu_inst (
		.op_code(op_code),
		.pc_increment(pc_increment),
		.a(y_data),
		.b(bus_data),
		.result(alu_result)
	);

endmodule

// File: testbench/datapath_tb.sv
`include "cpu_config.svh"

module datapath_tb
	import alu_pkg::*;
	import bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 10ps;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int STEPS = 2000;
	localparam int MARGIN = 100;
	localparam int SRC_COUNT = 6 + `REG_COUNT;
	localparam int SRC_W = $bits(bus_src_t);
	localparam int IDX_W = $clog2(`REG_COUNT);

	logic clk, arst_n, clr;
	logic pc_out, zlo_out, zhi_out, mdr_out, hi_out, lo_out;
	logic [`REG_COUNT-1:0] r_out, r_enable;
	logic mar_enable, z_enable, lo_enable, hi_enable, pc_enable;
	logic mdr_enable, read, ir_enable, y_enable, pc_increment;
	op_code_t op_code;
	word_t m_data_in;
	word_t bus_data, zlo_data, zhi_data, ir_data, mar_data;

	// Reference copy of every register
	word_t m_pc, m_ir, m_mar, m_y, m_hi, m_lo, m_mdr;
	word_t m_gpr [`REG_COUNT];
	dword_t m_z;

	int seed;
	int errors;
	int checks;
	bit pc_pending;
	bit pc_show;

	datapath uut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Expected bus value with the first strobed source in bus_src_t order winning
	function automatic word_t model_bus();
		logic [SRC_COUNT-1:0] req;
		bus_src_t src;
		req = {r_out, lo_out, hi_out, zhi_out, zlo_out, pc_out, mdr_out};
		src = src_none;
		for (int k = SRC_COUNT - 1; k >= 0; k--) begin
			if (req[SRC_W'(k)]) begin
				src = bus_src_t'(SRC_W'(k));
			end
		end
		case (src)
			src_mdr:  return m_mdr;
			src_pc:   return m_pc;
			src_zlo:  return m_z.lo;
			src_zhi:  return m_z.hi;
			src_hi:   return m_hi;
			src_lo:   return m_lo;
			src_none: return '0;
			default:  return m_gpr[IDX_W'(int'(src) - int'(src_r0))];
		endcase
	endfunction

	function automatic dword_t model_alu(input op_code_t op, input logic inc,
		input word_t a, input word_t b);
		dword_t r;
		int s;
		int sa;
		int sb;
		longint prod;
		r = '0;
		s = int'(b[4:0]);
		sa = int'(a);
		sb = int'(b);
		if (inc) begin
			r.lo = b + 32'd1;
			return r;
		end
		case (op)
			op_ld, op_ldi, op_st, op_add, op_addi: r.lo = a + b;
			op_sub: r.lo = a - b;
			op_and, op_andi: r.lo = a & b;
			op_or, op_ori: r.lo = a | b;
			op_shr: r.lo = a >> s;
			op_shra: r.lo = word_t'($signed(a) >>> s);
			op_shl: r.lo = a << s;
			op_ror: r.lo = (a >> s) | (a << (`DATA_WIDTH - s));
			op_rol: r.lo = (a << s) | (a >> (`DATA_WIDTH - s));
			op_mul: begin
				prod = longint'(sa) * longint'(sb);
				r = dword_t'(prod);
			end
			op_div: begin
				if (b == '0) begin
					r.lo = '1;
					r.hi = a;
				end else begin
					r.lo = word_t'(sa / sb);
					r.hi = word_t'(sa % sb);
				end
			end
			op_neg: r.lo = 32'd0 - b;
			op_not: r.lo = ~b;
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic clear_model();
		m_pc = '0;
		m_ir = '0;
		m_mar = '0;
		m_y = '0;
		m_hi = '0;
		m_lo = '0;
		m_mdr = '0;
		m_z = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			m_gpr[IDX_W'(i)] = '0;
		end
	endtask

	// Runs at the clock edge before the new strobes land
	task automatic update_model();
		word_t bus;
		dword_t res;
		bus = model_bus();
		res = model_alu(op_code, pc_increment, m_y, bus);
		if (clr) begin
			clear_model();
		end else begin
			if (pc_enable) m_pc = bus;
			if (ir_enable) m_ir = bus;
			if (mar_enable) m_mar = bus;
			if (y_enable) m_y = bus;
			if (hi_enable) m_hi = bus;
			if (lo_enable) m_lo = bus;
			if (z_enable) m_z = res;
			if (mdr_enable) m_mdr = read ? m_data_in : bus;
			for (int i = 0; i < `REG_COUNT; i++) begin
				if (r_enable[IDX_W'(i)]) m_gpr[IDX_W'(i)] = bus;
			end
		end
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_outputs();
		check_value("bus_data", bus_data, model_bus());
		check_value("zlo_data", zlo_data, m_z.lo);
		check_value("zhi_data", zhi_data, m_z.hi);
		check_value("ir_data", ir_data, m_ir);
		check_value("mar_data", mar_data, m_mar);
	endtask

	task automatic idle_inputs();
		clr <= 1'b0;
		{pc_out, zlo_out, zhi_out, mdr_out, hi_out, lo_out} <= '0;
		r_out <= '0;
		r_enable <= '0;
		{mar_enable, z_enable, lo_enable, hi_enable, pc_enable} <= '0;
		{mdr_enable, read, ir_enable, y_enable, pc_increment} <= '0;
	endtask

	// Index follows bus_src_t and anything past r7 leaves the bus idle
	task automatic drive_source(input int idx);
		case (idx)
			0: mdr_out <= 1'b1;
			1: pc_out <= 1'b1;
			2: zlo_out <= 1'b1;
			3: zhi_out <= 1'b1;
			4: hi_out <= 1'b1;
			5: lo_out <= 1'b1;
			default: if (idx < SRC_COUNT) r_out[IDX_W'(idx - 6)] <= 1'b1;
		endcase
	endtask

	task automatic drive_dest(input int idx);
		case (idx)
			8: ir_enable <= 1'b1;
			9: mar_enable <= 1'b1;
			10: hi_enable <= 1'b1;
			11: lo_enable <= 1'b1;
			12: pc_enable <= 1'b1;
			13: y_enable <= 1'b1;
			14: mdr_enable <= 1'b1;
			default: r_enable[IDX_W'(idx)] <= 1'b1;
		endcase
	endtask

	task automatic drive_step();
		int kind;
		idle_inputs();
		if (pc_pending) begin
			// Z low back into the PC after an increment
			zlo_out <= 1'b1;
			pc_enable <= 1'b1;
			pc_pending = 1'b0;
			pc_show = 1'b1;
		end else if (pc_show) begin
			pc_out <= 1'b1;
			pc_show = 1'b0;
		end else begin
			kind = rand_below(16);
			case (kind)
				0, 1: begin
					read <= 1'b1;
					mdr_enable <= 1'b1;
					// Small values keep shift amounts and divisors interesting
					if (rand_below(4) == 0) m_data_in <= word_t'(rand_below(64));
					else m_data_in <= word_t'($random(seed));
				end
				2, 3, 4: begin
					drive_source(rand_below(SRC_COUNT));
					drive_dest(rand_below(15));
				end
				5: begin
					drive_source(rand_below(SRC_COUNT));
					y_enable <= 1'b1;
				end
				6, 7, 8: begin
					drive_source(rand_below(SRC_COUNT + 2));
					op_code <= op_code_t'(5'(rand_below(32)));
					z_enable <= 1'b1;
				end
				9: begin
					pc_out <= 1'b1;
					pc_increment <= 1'b1;
					z_enable <= 1'b1;
					op_code <= op_code_t'(5'(rand_below(32)));
					pc_pending = 1'b1;
				end
				10: begin
					if (rand_below(2) == 0) zlo_out <= 1'b1;
					else zhi_out <= 1'b1;
					drive_dest(rand_below(15));
				end
				11: begin
					repeat (2 + rand_below(3)) drive_source(rand_below(SRC_COUNT));
					drive_dest(rand_below(15));
				end
				12: begin
					if (rand_below(8) == 0) clr <= 1'b1;
					else drive_source(rand_below(SRC_COUNT + 1));
				end
				default: drive_source(rand_below(SRC_COUNT + 1));
			endcase
		end
	endtask

	initial begin
		seed = 32'hd3aa8f57;
		errors = 0;
		checks = 0;
		pc_pending = 1'b0;
		pc_show = 1'b0;
		arst_n <= 1'b0;
		op_code <= op_ld;
		m_data_in <= '0;
		idle_inputs();
		clear_model();
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_outputs();
		repeat (STEPS) begin
			@(posedge clk);
			update_model();
			drive_step();
			@(negedge clk);
			check_outputs();
		end
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(CLK_PERIOD * (STEPS + RESET_CYCLES + MARGIN));
		$display("Timeout: the run did not finish within its cycle budget");
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+logic
logic/alu_pkg.sv
logic/bus_pkg.sv
logic/data_register.sv
logic/mdr_unit.sv
logic/bus_mux.sv
logic/alu.sv
logic/datapath.sv
testbench/datapath_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f filelist.f \
	--top-module datapath_tb -o datapath_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build error"; exit 1; }

./obj_dir/datapath_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

grep -q "Testbench failed" sim.log && { echo "Simulation FAIL"; exit 1; } \
	|| { echo "Simulation PASS"; exit 0; }
